/* src/tlu_pkg.sv */
// shared widths, trigger mode and data format codes, FSM state encoding
// and the data-word union for the trigger controller
`default_nettype none

package tlu_pkg;

    localparam int DATA_W = 32;   // data word and trigger counter
    localparam int TS_W   = 32;   // free-running timestamp
    localparam int CFG_W  = 8;    // threshold, accept wait, low timeout

    // saturation value of the trigger-high counter
    localparam logic [CFG_W-1:0] HIGH_COUNT_MAX = 8'd255;

    typedef enum logic [1:0] {
        MODE_SELF_EDGE     = 2'b00,
        MODE_SELF_ALT      = 2'b01,
        MODE_TLU_HANDSHAKE = 2'b10,
        MODE_RESERVED      = 2'b11   // accepts no trigger
    } mode_t;

    // 2'b11 falls back to the counter layout
    typedef enum logic [1:0] {
        FMT_COUNTER   = 2'b00,
        FMT_TIMESTAMP = 2'b01,
        FMT_COMBINED  = 2'b10
    } format_t;

    typedef enum logic [2:0] {
        ST_IDLE             = 3'd0,
        ST_SEND_COMMAND     = 3'd1,
        ST_WAIT_TRIGGER_LOW = 3'd2,
        ST_LATCH_DATA       = 3'd3,
        ST_WAIT_ACK         = 3'd4
    } state_t;

    // one readout word, two layouts behind the marker bit
    typedef union packed {
        struct packed {
            logic        marker;
            logic [30:0] value;      // counter or timestamp
        } number_view;
        struct packed {
            logic        marker;
            logic [14:0] ts_low;
            logic [15:0] count_low;
        } combined_view;
    } trigger_word_u;

endpackage

`default_nettype wire

/* src/trigger_input_filter.sv */
// trigger input filter: edge detection, saturating high-time counter
// and the per-mode start qualifier
`timescale 1ns/1ns
`default_nettype none

module trigger_input_filter (
    input  logic                      trigger_clk,
    input  logic                      reset,
    input  logic                      trigger,
    input  logic                      trigger_enable,
    input  tlu_pkg::mode_t            trigger_mode,
    input  logic [tlu_pkg::CFG_W-1:0] trigger_threshold,
    input  logic [tlu_pkg::CFG_W-1:0] handshake_accept_wait_cycles,
    input  logic                      trigger_accepted_flag,
    output logic                      trigger_edge,
    output logic                      trigger_start
);
    import tlu_pkg::*;

    logic             trigger_ff;
    logic             trigger_enable_ff;
    logic             enable_rise;
    logic [CFG_W-1:0] high_cnt;
    logic             threshold_accept;
    logic             handshake_accept;
    logic             self_start;
    logic             handshake_start;

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            trigger_ff        <= 1'b0;
            trigger_enable_ff <= 1'b0;
        end
        else
        begin
            trigger_ff        <= trigger;
            trigger_enable_ff <= trigger_enable;
        end
    end

    assign trigger_edge = trigger & ~trigger_ff;
    assign enable_rise  = trigger_enable & ~trigger_enable_ff;   // TLU may already be high

    // high-time counter, started by an edge and held at its maximum
    always_ff @(posedge trigger_clk)
    begin
        if (reset || trigger_accepted_flag || !trigger_enable || !trigger)
            high_cnt <= '0;
        else if (high_cnt == '0)
            high_cnt <= trigger_edge ? 8'd1 : 8'd0;
        else if (high_cnt != HIGH_COUNT_MAX)
            high_cnt <= high_cnt + 1'b1;
    end

    // accept bits, one cycle behind the counter
    always_ff @(posedge trigger_clk)
    begin
        if (reset || trigger_accepted_flag)
        begin
            threshold_accept <= 1'b0;
            handshake_accept <= 1'b0;
        end
        else
        begin
            threshold_accept <= (trigger_threshold != '0) && (high_cnt >= trigger_threshold);
            handshake_accept <= (handshake_accept_wait_cycles != '0)
                                && (high_cnt >= handshake_accept_wait_cycles);
        end
    end

    assign self_start = ((trigger_threshold == '0) && trigger_edge)
                        || ((trigger_threshold != '0) && threshold_accept);

    assign handshake_start = (trigger && enable_rise)
                             || ((handshake_accept_wait_cycles == '0) && trigger_edge)
                             || ((handshake_accept_wait_cycles != '0) && handshake_accept);

    always_comb
    begin
        case (trigger_mode)
            MODE_SELF_EDGE,
            MODE_SELF_ALT:      trigger_start = self_start;
            MODE_TLU_HANDSHAKE: trigger_start = handshake_start;
            default:            trigger_start = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/trigger_handshake_fsm.sv */
// trigger FSM with busy and preempt outputs, acknowledge latches
// and the trigger low-time timeout error
`timescale 1ns/1ns
`default_nettype none

module trigger_handshake_fsm (
    input  logic                      trigger_clk,
    input  logic                      reset,
    input  logic                      trigger,
    input  logic                      trigger_enable,
    input  logic                      trigger_veto,
    input  tlu_pkg::mode_t            trigger_mode,
    input  logic                      trigger_start,
    input  logic [tlu_pkg::CFG_W-1:0] trigger_low_timeout,
    input  logic                      trigger_acknowledge,
    input  logic                      fifo_acknowledge,
    output logic                      trigger_accepted_flag,
    output logic                      trigger_data_write,
    output logic                      fifo_preempt_req,
    output logic                      tlu_busy,
    output logic                      low_timeout_error_flag
);
    import tlu_pkg::*;

    state_t           state;
    state_t           next_state;
    logic [CFG_W-1:0] low_cnt;
    logic             timeout_error;
    logic             timeout_hit;
    logic             trigger_acked;
    logic             fifo_acked;
    logic             self_mode;
    logic             handshake_mode;
    logic             accept_ok;

    assign self_mode      = (trigger_mode == MODE_SELF_EDGE) || (trigger_mode == MODE_SELF_ALT);
    assign handshake_mode = (trigger_mode == MODE_TLU_HANDSHAKE);

    // both parties idle and triggering enabled
    assign accept_ok = trigger_start && trigger_enable
                       && !trigger_acknowledge && !fifo_acknowledge;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (accept_ok && self_mode && !trigger_veto)   // veto only in self modes
                    next_state = ST_SEND_COMMAND;
                else if (accept_ok && handshake_mode)
                    next_state = ST_WAIT_TRIGGER_LOW;
            end
            ST_SEND_COMMAND:
                next_state = ST_LATCH_DATA;
            ST_WAIT_TRIGGER_LOW:
            begin
                if (!trigger || timeout_error)
                    next_state = ST_LATCH_DATA;
            end
            ST_LATCH_DATA:
                next_state = ST_WAIT_ACK;
            ST_WAIT_ACK:
            begin
                if (trigger_acked && fifo_acked)
                    next_state = ST_IDLE;
            end
            default:
                next_state = ST_IDLE;
        endcase
    end

    // low-wait counter compared while the TLU still holds trigger high
    assign timeout_hit = (next_state == ST_WAIT_TRIGGER_LOW)
                         && (trigger_low_timeout != '0)
                         && (low_cnt >= trigger_low_timeout);

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            state                  <= ST_IDLE;
            trigger_accepted_flag  <= 1'b0;
            trigger_data_write     <= 1'b0;
            fifo_preempt_req       <= 1'b0;
            tlu_busy               <= 1'b0;
            low_cnt                <= '0;
            timeout_error          <= 1'b0;
            low_timeout_error_flag <= 1'b0;
        end
        else
        begin
            state                 <= next_state;
            trigger_accepted_flag <= (state == ST_IDLE) && (next_state != ST_IDLE);
            trigger_data_write    <= (next_state == ST_LATCH_DATA);
            fifo_preempt_req      <= (next_state != ST_IDLE);
            tlu_busy              <= (next_state != ST_IDLE) && handshake_mode;

            if (next_state == ST_WAIT_TRIGGER_LOW)
            begin
                if (low_cnt != '1)
                    low_cnt <= low_cnt + 1'b1;   // saturates
            end
            else
            begin
                low_cnt <= '0;
            end

            timeout_error          <= timeout_hit;
            low_timeout_error_flag <= timeout_hit && !timeout_error;   // rising edge only
        end
    end

    // acknowledges may arrive any time after the accept
    always_ff @(posedge trigger_clk)
    begin
        if (reset || next_state == ST_IDLE)
        begin
            trigger_acked <= 1'b0;
            fifo_acked    <= 1'b0;
        end
        else
        begin
            if (trigger_acknowledge)
                trigger_acked <= 1'b1;
            if (fifo_acknowledge)
                fifo_acked <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/trigger_word_formatter.sv */
// free-running timestamp, settable trigger counter and
// readout word formatting on every accepted trigger
`timescale 1ns/1ns
`default_nettype none

module trigger_word_formatter (
    input  logic                       trigger_clk,
    input  logic                       reset,
    input  logic                       timestamp_reset,
    input  logic                       trigger_counter_set,
    input  logic [tlu_pkg::DATA_W-1:0] trigger_counter_set_value,
    input  logic                       trigger_accepted_flag,
    input  tlu_pkg::format_t           conf_data_format,
    output logic [tlu_pkg::TS_W-1:0]   timestamp,
    output logic [tlu_pkg::DATA_W-1:0] trigger_data
);
    import tlu_pkg::*;

    logic [DATA_W-1:0] trigger_counter;
    trigger_word_u     word_next;

    always_ff @(posedge trigger_clk)
    begin
        if (reset || timestamp_reset)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    // a set request wins over the increment
    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_counter <= '0;
        else if (trigger_counter_set)
            trigger_counter <= trigger_counter_set_value;
        else if (trigger_accepted_flag)
            trigger_counter <= trigger_counter + 1'b1;
    end

    // word built from the values seen at the accept, before the increment
    always_comb
    begin
        word_next = '0;
        case (conf_data_format)
            FMT_TIMESTAMP:
            begin
                word_next.number_view.marker = 1'b1;
                word_next.number_view.value  = timestamp[30:0];
            end
            FMT_COMBINED:
            begin
                word_next.combined_view.marker    = 1'b1;
                word_next.combined_view.ts_low    = timestamp[14:0];
                word_next.combined_view.count_low = trigger_counter[15:0];
            end
            default:
            begin
                word_next.number_view.marker = 1'b1;   // counter only
                word_next.number_view.value  = trigger_counter[30:0];
            end
        endcase
    end

    // held until the next accepted trigger
    always_ff @(posedge trigger_clk)
    begin
        if (trigger_accepted_flag)
            trigger_data <= word_next;
    end

endmodule

`default_nettype wire

/* src/tlu_trigger_ctrl.sv */
// trigger-logic controller top level
// input filter, handshake FSM and data-word formatter
`timescale 1ns/1ns
`default_nettype none

module tlu_trigger_ctrl (
    input  logic                       trigger_clk,
    input  logic                       reset,
    input  logic                       trigger,
    input  logic                       trigger_enable,
    input  logic                       trigger_veto,
    input  tlu_pkg::mode_t             trigger_mode,
    input  logic [tlu_pkg::CFG_W-1:0]  trigger_threshold,
    input  logic [tlu_pkg::CFG_W-1:0]  handshake_accept_wait_cycles,
    input  logic [tlu_pkg::CFG_W-1:0]  trigger_low_timeout,
    input  logic                       trigger_acknowledge,
    input  logic                       fifo_acknowledge,
    input  logic                       timestamp_reset,
    input  logic                       trigger_counter_set,
    input  logic [tlu_pkg::DATA_W-1:0] trigger_counter_set_value,
    input  tlu_pkg::format_t           conf_data_format,
    output logic                       trigger_accepted_flag,
    output logic                       trigger_data_write,
    output logic                       fifo_preempt_req,
    output logic                       tlu_busy,
    output logic                       low_timeout_error_flag,
    output logic [tlu_pkg::TS_W-1:0]   timestamp,
    output logic [tlu_pkg::DATA_W-1:0] trigger_data
);

    logic trigger_start;   // filter to FSM

    // the edge itself is consumed inside the filter
    trigger_input_filter i_trigger_input_filter (
        .trigger_clk                  (trigger_clk),
        .reset                        (reset),
        .trigger                      (trigger),
        .trigger_enable               (trigger_enable),
        .trigger_mode                 (trigger_mode),
        .trigger_threshold            (trigger_threshold),
        .handshake_accept_wait_cycles (handshake_accept_wait_cycles),
        .trigger_accepted_flag        (trigger_accepted_flag),
        .trigger_edge                 (),
        .trigger_start                (trigger_start)
    );

    trigger_handshake_fsm i_trigger_handshake_fsm (
        .trigger_clk            (trigger_clk),
        .reset                  (reset),
        .trigger                (trigger),
        .trigger_enable         (trigger_enable),
        .trigger_veto           (trigger_veto),
        .trigger_mode           (trigger_mode),
        .trigger_start          (trigger_start),
        .trigger_low_timeout    (trigger_low_timeout),
        .trigger_acknowledge    (trigger_acknowledge),
        .fifo_acknowledge       (fifo_acknowledge),
        .trigger_accepted_flag  (trigger_accepted_flag),
        .trigger_data_write     (trigger_data_write),
        .fifo_preempt_req       (fifo_preempt_req),
        .tlu_busy               (tlu_busy),
        .low_timeout_error_flag (low_timeout_error_flag)
    );

    trigger_word_formatter i_trigger_word_formatter (
        .trigger_clk               (trigger_clk),
        .reset                     (reset),
        .timestamp_reset           (timestamp_reset),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .conf_data_format          (conf_data_format),
        .timestamp                 (timestamp),
        .trigger_data              (trigger_data)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tlu_trigger_ctrl_tb.sv */
// testbench for the trigger controller: stimulus, counter model,
// assertions, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

module tlu_trigger_ctrl_tb;
    import tlu_pkg::*;

    localparam int RESET_CYCLES     = 16;
    localparam int PULSE_COUNT      = 26;   // trigger pulses over all tests
    localparam int CYCLES_PER_PULSE = 40;   // pulse, handshake and return to idle
    localparam int TEST_CYCLES      = RESET_CYCLES + PULSE_COUNT * CYCLES_PER_PULSE;
    localparam int MARGIN           = 500;

    logic        trigger_clk, reset;
    logic        trigger, trigger_enable, trigger_veto;
    mode_t       trigger_mode;
    logic [7:0]  trigger_threshold, handshake_accept_wait_cycles, trigger_low_timeout;
    logic        trigger_acknowledge, fifo_acknowledge, timestamp_reset;
    logic        trigger_counter_set;
    logic [31:0] trigger_counter_set_value;
    format_t     conf_data_format;
    logic        trigger_accepted_flag, trigger_data_write, fifo_preempt_req;
    logic        tlu_busy, low_timeout_error_flag;
    logic [31:0] timestamp, trigger_data;

    int          seed = 7;
    int          errors = 0;
    int          flag_cnt = 0;
    int          write_cnt = 0;
    int          tout_cnt = 0;
    logic        fifo_ack_hold = 1'b0;
    logic        tack_seen = 1'b0;
    logic        fack_seen = 1'b0;
    logic [31:0] model_cnt, model_ts, cap_cnt, cap_ts, exp_word;
    logic        self_mode;

    tb_clock_gen i_tb_clock_gen (.clk(trigger_clk), .reset(reset));

    tlu_trigger_ctrl i_tlu_trigger_ctrl (.*);

    assign self_mode = (trigger_mode == MODE_SELF_EDGE) || (trigger_mode == MODE_SELF_ALT);

    function automatic logic [31:0] expected_word(input format_t fmt, input logic [31:0] cnt,
                                                  input logic [31:0] ts);
        case (fmt)
            FMT_TIMESTAMP: expected_word = {1'b1, ts[30:0]};
            FMT_COMBINED:  expected_word = {1'b1, ts[14:0], cnt[15:0]};
            default:       expected_word = {1'b1, cnt[30:0]};
        endcase
    endfunction

    // timestamp model, one count per cycle
    always @(posedge trigger_clk)
    begin
        if (reset || timestamp_reset)
            model_ts <= '0;
        else
            model_ts <= model_ts + 1;
    end

    // counter model, capture uses the value before the increment
    always @(posedge trigger_clk)
    begin
        if (reset)
            model_cnt <= '0;
        else if (trigger_counter_set)
            model_cnt <= trigger_counter_set_value;
        else if (trigger_accepted_flag)
            model_cnt <= model_cnt + 1;
        if (!reset && trigger_accepted_flag)
        begin
            cap_cnt <= model_cnt;
            cap_ts  <= model_ts;
        end
    end

    always @(posedge trigger_clk)
    begin
        if (!reset)
        begin
            assert (timestamp == model_ts)
            else
            begin
                errors++;
                $display("** Error at %0t ns: timestamp expected %h actual %h",
                         $time, model_ts, timestamp);
            end
            if (trigger_accepted_flag)
                flag_cnt++;
            if (low_timeout_error_flag)
                tout_cnt++;
            if (trigger_acknowledge)
                tack_seen <= 1'b1;
            if (fifo_acknowledge)
                fack_seen <= 1'b1;
            if (trigger_accepted_flag)
            begin
                tack_seen <= 1'b0;   // fresh handshake
                fack_seen <= 1'b0;
            end
            if (trigger_data_write)
            begin
                write_cnt++;
                exp_word = expected_word(conf_data_format, cap_cnt, cap_ts);
                assert (trigger_data == exp_word)
                else
                begin
                    errors++;
                    $display("** Error at %0t ns: trigger_data expected %h actual %h",
                             $time, exp_word, trigger_data);
                end
            end
        end
    end

    // accept one cycle after a qualifying edge, write one cycle later
    assert property (@(posedge trigger_clk) disable iff (reset)
        (self_mode && trigger_threshold == 0 && $rose(trigger) && !fifo_preempt_req
         && !trigger_acknowledge && !fifo_acknowledge && trigger_enable && !trigger_veto)
        |=> trigger_accepted_flag)
    else
    begin
        errors++;
        $display("missing trigger_accepted_flag after a rising trigger edge at %0t ns", $time);
    end

    assert property (@(posedge trigger_clk) disable iff (reset)
        (trigger_accepted_flag && self_mode) |=> trigger_data_write)
    else
    begin
        errors++;
        $display("missing trigger_data_write two cycles after the edge at %0t ns", $time);
    end

    // preempt (and busy with it) rises exactly with the flag
    assert property (@(posedge trigger_clk) disable iff (reset)
        trigger_accepted_flag |-> $rose(fifo_preempt_req))
    else
    begin
        errors++;
        $display("fifo_preempt_req did not rise with trigger_accepted_flag at %0t ns", $time);
    end

    assert property (@(posedge trigger_clk) disable iff (reset)
        (trigger_data_write && trigger_mode == MODE_TLU_HANDSHAKE)
        |-> (!$past(trigger) || $past(low_timeout_error_flag)))
    else
    begin
        errors++;
        $display("write issued while the TLU trigger was still high at %0t ns", $time);
    end

    assert property (@(posedge trigger_clk) disable iff (reset)
        tlu_busy == (fifo_preempt_req && trigger_mode == MODE_TLU_HANDSHAKE))
    else
    begin
        errors++;
        $display("** Error at %0t ns: tlu_busy expected %b actual %b", $time,
                 fifo_preempt_req && trigger_mode == MODE_TLU_HANDSHAKE, tlu_busy);
    end

    assert property (@(posedge trigger_clk) disable iff (reset)
        $fell(fifo_preempt_req) |-> (tack_seen && fack_seen))
    else
    begin
        errors++;
        $display("returned to idle before both acknowledges at %0t ns", $time);
    end

    assert property (@(posedge trigger_clk) disable iff (reset)
        low_timeout_error_flag |=> !low_timeout_error_flag)
    else
    begin
        errors++;
        $display("low_timeout_error_flag longer than one cycle at %0t ns", $time);
    end

    // acknowledges a few cycles after each write
    always
    begin
        int rnd;
        @(posedge trigger_clk);
        if (!reset && trigger_data_write)
        begin
            rnd = $random(seed);
            repeat (rnd & 3) @(posedge trigger_clk);
            #1;
            trigger_acknowledge = 1'b1;
            if (!fifo_ack_hold)
                fifo_acknowledge = 1'b1;
            @(posedge trigger_clk);
            #1;
            trigger_acknowledge = 1'b0;
            if (!fifo_ack_hold)
                fifo_acknowledge = 1'b0;
        end
    end

    task automatic step();
        @(posedge trigger_clk);
        #1;
    endtask

    task automatic pulse_trigger(input int len);
        trigger = 1'b1;
        repeat (len) step();
        trigger = 1'b0;
        step();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        repeat (3) step();
        while (fifo_preempt_req && n < 300)
        begin
            step();
            n++;
        end
        if (n >= 300)
        begin
            errors++;
            $display("timed out waiting for the return to idle at %0t ns", $time);
        end
        step();
    endtask

    task automatic expect_count(input string what, input int exp, input int act);
        assert (exp == act)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d actual %0d", $time, what, exp, act);
        end
    endtask

    initial
    begin
        int rnd;
        int base;
        int low_seen;
        trigger = 0;
        trigger_enable = 0;
        trigger_veto = 0;
        trigger_mode = MODE_SELF_EDGE;
        trigger_threshold = 0;
        handshake_accept_wait_cycles = 0;
        trigger_low_timeout = 0;
        trigger_acknowledge = 0;
        fifo_acknowledge = 0;
        timestamp_reset = 0;
        trigger_counter_set = 0;
        trigger_counter_set_value = 0;
        conf_data_format = FMT_COUNTER;
        @(negedge reset);
        step();
        assert (!trigger_data_write && !trigger_accepted_flag && !fifo_preempt_req
                && !tlu_busy && !low_timeout_error_flag)
        else
        begin
            errors++;
            $display("outputs not low after reset at %0t ns", $time);
        end
        trigger_enable = 1;
        step();

        // self mode, counter words
        base = flag_cnt;
        for (int i = 0; i < 10; i++)
        begin
            rnd = $random(seed);
            pulse_trigger(1 + (rnd & 3));
            wait_idle();
        end
        expect_count("accepted triggers", base + 10, flag_cnt);

        // counter set, then combined and timestamp layouts
        trigger_counter_set_value = 32'h1234_abcd;
        trigger_counter_set = 1;
        step();
        trigger_counter_set = 0;
        conf_data_format = FMT_COMBINED;
        pulse_trigger(2);
        wait_idle();
        conf_data_format = FMT_TIMESTAMP;
        pulse_trigger(2);
        wait_idle();
        conf_data_format = FMT_COUNTER;
        pulse_trigger(2);
        wait_idle();

        // threshold filter
        trigger_threshold = 5;
        base = flag_cnt;
        for (int len = 1; len < 5; len++)
        begin
            pulse_trigger(len);
            wait_idle();
        end
        expect_count("flags for short pulses", base, flag_cnt);
        pulse_trigger(9);
        wait_idle();
        expect_count("flags for a long pulse", base + 1, flag_cnt);
        trigger_threshold = 0;

        // TLU handshake, trigger dropped by the TLU
        trigger_mode = MODE_TLU_HANDSHAKE;
        step();
        base = flag_cnt;
        pulse_trigger(8);
        wait_idle();
        expect_count("handshake accepts", base + 1, flag_cnt);

        // low-time timeout with trigger stuck high
        trigger_low_timeout = 4;
        base = write_cnt;
        low_seen = tout_cnt;
        pulse_trigger(20);
        wait_idle();
        expect_count("timeout pulses", low_seen + 1, tout_cnt);
        expect_count("writes after timeout", base + 1, write_cnt);
        trigger_low_timeout = 0;

        // back-pressure from the FIFO
        trigger_mode = MODE_SELF_EDGE;
        fifo_ack_hold = 1;
        step();
        base = flag_cnt;
        pulse_trigger(2);
        repeat (4) step();
        for (int i = 0; i < 4; i++)
        begin
            pulse_trigger(2);
            assert (fifo_preempt_req)
            else
            begin
                errors++;
                $display("fifo_preempt_req dropped under back-pressure at %0t ns", $time);
            end
        end
        expect_count("flags under back-pressure", base + 1, flag_cnt);
        fifo_acknowledge = 1;
        step();
        fifo_acknowledge = 0;
        fifo_ack_hold = 0;
        wait_idle();
        pulse_trigger(2);
        wait_idle();
        expect_count("flags after release", base + 2, flag_cnt);

        $display("summary: %0d errors, %0d accepts, %0d writes, %0d timeouts",
                 errors, flag_cnt, write_cnt, tout_cnt);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #((TEST_CYCLES + MARGIN) * 4);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/tlu_pkg.sv
src/trigger_input_filter.sv
src/trigger_handshake_fsm.sv
src/trigger_word_formatter.sv
src/tlu_trigger_ctrl.sv
tests/tb_clock_gen.sv
tests/tlu_trigger_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the trigger controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tlu_trigger_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtlu_trigger_ctrl_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
